// File: dv/csr_trace.txt
// columns: op addr data expected, all hex
// ops 1 write, 2 read with data as mask, 3 random write and read back, 4 excp with
// addr {subcode,code} and data era, 5 ertn expecting plv, 6 hw lines, 7 idle,
// 8 has_int, 9 counter step over data cycles, 0 end
2 0000 ffffffff 00000000
2 0004 ffffffff 00000000
2 0005 ffffffff 00000000
2 0041 ffffffff 00000000
2 0042 ffffffff ffffffff
8 0000 00000000 00000000
3 0030 00000000 00000000
3 0031 00000000 00000000
3 0032 00000000 00000000
3 0033 00000000 00000000
1 000c 12345677 00000000
2 000c ffffffff 12345640
1 0040 cafef00d 00000000
2 0040 ffffffff cafef00d
1 0004 ffffffff 00000000
2 0004 ffffffff 00001fff
1 0001 ffffffff 00000000
2 0001 ffffffff 00000007
1 0005 ffffffff 00000000
2 0005 ffffffff 00000003
1 0005 00000000 00000000
1 0000 00000007 00000000
4 004b 1c000100 00000000
2 0001 ffffffff 00000007
2 0000 ffffffff 00000000
2 0006 ffffffff 1c000100
2 0005 7fff0000 004b0000
5 0000 00000000 00000003
2 0000 ffffffff 00000007
1 0004 00000010 00000000
6 0000 00000024 00000000
2 0005 000003fc 00000090
8 0000 00000000 00000001
1 0004 00000000 00000000
8 0000 00000000 00000000
6 0000 00000000 00000000
1 0004 00000800 00000000
1 0041 00000009 00000000
2 0042 ffffffff 00000008
7 0000 00000007 00000000
2 0005 00000800 00000000
2 0005 00000800 00000800
8 0000 00000000 00000001
1 0044 00000001 00000000
2 0005 00000800 00000000
7 0000 00000004 00000000
2 0005 00000800 00000000
2 0042 ffffffff ffffffff
1 0041 00000007 00000000
7 0000 00000005 00000000
2 0005 00000800 00000800
1 0044 00000001 00000000
2 0005 00000800 00000000
7 0000 00000001 00000000
2 0005 00000800 00000000
2 0005 00000800 00000800
9 0000 00000007 00000007
9 0000 00000015 00000015
0 0000 00000000 00000000

// File: files.f
design/csr_pkg.sv
design/csr_bus_if.sv
design/exc_status_if.sv
design/csr_exc_state.sv
design/csr_timer.sv
design/csr_read_irq.sv
design/csr_top.sv
dv/csr_props.sv
dv/csr_tb.sv

// File: Bender.yml
package:
  name: csr_block

sources:
  - files:
      - design/csr_pkg.sv
      - design/csr_bus_if.sv
      - design/exc_status_if.sv
      - design/csr_exc_state.sv
      - design/csr_timer.sv
      - design/csr_read_irq.sv
      - design/csr_top.sv
  - target: test
    files:
      - dv/csr_props.sv
      - dv/csr_tb.sv

// File: dv/csr_tb.sv
module csr_tb;

  localparam int          PERIOD     = 100;
  localparam int          RESET_CYC  = 16;
  localparam int          DRIVE_DLY  = 10;
  localparam int unsigned SEED       = 32'h64ecb5d7;
  localparam string       TRACE_FILE = "dv/csr_trace.txt";
  localparam int          MAX_OPS    = 64;

  // trace operation codes
  localparam int OP_END    = 0;
  localparam int OP_WRITE  = 1;
  localparam int OP_READ   = 2;
  localparam int OP_WRAND  = 3;
  localparam int OP_EXCP   = 4;
  localparam int OP_ERTN   = 5;
  localparam int OP_LINES  = 6;
  localparam int OP_IDLE   = 7;
  localparam int OP_HASINT = 8;
  localparam int OP_COUNT  = 9;

  logic                                  clk;
  logic                                  resetn;
  csr_pkg::csr_addr_t                    raddr;
  csr_pkg::csr_data_t                    rdata;
  logic                                  wen;
  csr_pkg::csr_addr_t                    waddr;
  csr_pkg::csr_data_t                    wdata;
  logic [csr_pkg::HWI_W-1:0]             interrupt;
  logic                                  excp;
  logic                                  ertn;
  csr_pkg::csr_data_t                    era;
  logic [csr_pkg::ECODE_W-1:0]           code;
  logic [csr_pkg::ESUBCODE_W-1:0]        subcode;
  logic                                  has_int;
  logic [csr_pkg::PLV_W-1:0]             plv;
  csr_pkg::csr_data_t                    era_out;
  csr_pkg::csr_data_t                    eentry_out;
  csr_pkg::csr_data_t                    tid_out;
  logic [csr_pkg::CNT_W-1:0]             counter_out;

  logic [31:0] trace_mem [0:4*MAX_OPS-1];
  int          err_count = 0;
  longint      budget = 0;

  csr_top dut_i (.*);

  always #(PERIOD / 2) clk = ~clk;

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      err_count++;
      $display("FAIL t=%0t %s expected %h actual %h", $time, name, expected, actual);
      $display("Finished with errors");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic drive_write(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_data_t data);
    wen   = 1'b1;
    waddr = addr;
    wdata = data;
    next_cycle();
    wen = 1'b0;
  endtask

  // sample in the low phase, well clear of both edges
  task automatic read_check(input csr_pkg::csr_addr_t addr, input logic [31:0] mask,
                            input logic [31:0] expected);
    raddr = addr;
    #(PERIOD / 2);
    check_value($sformatf("rdata@%h", addr), rdata & mask, expected);
    if (addr == csr_pkg::ADDR_EENTRY) begin
      check_value("eentry_out", eentry_out & mask, expected);
    end
    if (addr == csr_pkg::ADDR_TID) begin
      check_value("tid_out", tid_out & mask, expected);
    end
    next_cycle();
  endtask

  task automatic run_op(input logic [31:0] op, input logic [31:0] addr,
                        input logic [31:0] data, input logic [31:0] expd);
    logic [31:0] rnd;
    logic [63:0] first;
    case (op)
      OP_WRITE: drive_write(addr[13:0], data);
      OP_READ:  read_check(addr[13:0], data, expd);
      OP_WRAND: begin
        rnd = $urandom();
        drive_write(addr[13:0], rnd);
        read_check(addr[13:0], 32'hffff_ffff, rnd);
      end
      OP_EXCP: begin
        excp    = 1'b1;
        era     = data;
        code    = addr[5:0];
        subcode = addr[14:6];
        next_cycle();
        excp = 1'b0;
        check_value("plv", plv, 64'd0);
        check_value("era_out", era_out, data);
      end
      OP_ERTN: begin
        ertn = 1'b1;
        next_cycle();
        ertn = 1'b0;
        check_value("plv", plv, expd[1:0]);
      end
      OP_LINES: begin
        interrupt = data[7:0];
        next_cycle();
      end
      OP_IDLE: repeat (data) next_cycle();
      OP_HASINT: begin
        #(PERIOD / 2);
        check_value("has_int", has_int, expd[0]);
        next_cycle();
      end
      OP_COUNT: begin
        first = counter_out;
        repeat (data) next_cycle();
        check_value("counter_out step", counter_out - first, expd);
      end
      default: begin
        err_count++;
        $display("trace holds an unknown operation code %h", op);
        $display("Finished with errors");
        $fatal(1, "bad trace entry");
      end
    endcase
  endtask

  initial begin
    int     i;
    int     n_ops;
    longint cycles;
    clk       = 1'b0;
    resetn    = 1'b0;
    raddr     = '0;
    wen       = 1'b0;
    waddr     = '0;
    wdata     = '0;
    interrupt = '0;
    excp      = 1'b0;
    ertn      = 1'b0;
    era       = '0;
    code      = '0;
    subcode   = '0;
    void'($urandom(SEED));
    for (i = 0; i < 4 * MAX_OPS; i++) begin
      trace_mem[i] = '0;
    end
    $readmemh(TRACE_FILE, trace_mem);
    n_ops  = 0;
    cycles = RESET_CYC;
    while (n_ops < MAX_OPS && trace_mem[4*n_ops] != OP_END) begin
      cycles += 2;
      if (trace_mem[4*n_ops] == OP_IDLE || trace_mem[4*n_ops] == OP_COUNT) begin
        cycles += trace_mem[4*n_ops+2];
      end
      n_ops++;
    end
    budget = cycles * PERIOD * 2;
    repeat (RESET_CYC) @(posedge clk);
    #DRIVE_DLY;
    resetn = 1'b1;
    for (i = 0; i < n_ops; i++) begin
      run_op(trace_mem[4*i], trace_mem[4*i+1], trace_mem[4*i+2], trace_mem[4*i+3]);
    end
    if (err_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // watchdog sized from the trace
  initial begin
    wait (budget > 0);
    #(budget);
    $display("timeout: trace did not complete within %0d time units", budget);
    $display("Finished with errors");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: dv/csr_props.sv
module csr_props (
  input logic                      clk,
  input logic                      resetn,
  input logic                      ie,
  input logic                      has_int,
  input logic                      excp,
  input logic [csr_pkg::PLV_W-1:0] plv
);

  // exception entry masks interrupts
  excp_masks_int: assert property (
    @(posedge clk) disable iff (!resetn) excp |=> !ie && !has_int
  ) else $error("crmd.ie or has_int high in the cycle after excp");

  // exception entry drops to kernel level
  excp_clears_plv: assert property (
    @(posedge clk) disable iff (!resetn) excp |=> plv == '0
  ) else $error("plv not zero in the cycle after excp");

endmodule

bind csr_top csr_props props_i (
  .clk     (clk),
  .resetn  (resetn),
  .ie      (stat_if.ie),
  .has_int (has_int),
  .excp    (excp),
  .plv     (plv)
);

// File: design/csr_top.sv
module csr_top (
  input  logic                              clk,
  input  logic                              resetn,
  input  csr_pkg::csr_addr_t                raddr,
  output csr_pkg::csr_data_t                rdata,
  input  logic                              wen,
  input  csr_pkg::csr_addr_t                waddr,
  input  csr_pkg::csr_data_t                wdata,
  input  logic [csr_pkg::HWI_W-1:0]         interrupt,
  input  logic                              excp,
  input  logic                              ertn,
  input  csr_pkg::csr_data_t                era,
  input  logic [csr_pkg::ECODE_W-1:0]       code,
  input  logic [csr_pkg::ESUBCODE_W-1:0]    subcode,
  output logic                              has_int,
  output logic [csr_pkg::PLV_W-1:0]         plv,
  output csr_pkg::csr_data_t                era_out,
  output csr_pkg::csr_data_t                eentry_out,
  output csr_pkg::csr_data_t                tid_out,
  output logic [csr_pkg::CNT_W-1:0]         counter_out
);

  csr_pkg::csr_data_t timer_rdata;
  logic               timer_irq;

  csr_bus_if    bus_if ();
  exc_status_if stat_if ();

  assign bus_if.wen   = wen;
  assign bus_if.waddr = waddr;
  assign bus_if.wdata = wdata;
  assign bus_if.raddr = raddr;

  csr_exc_state u_exc_state (
    .clk        (clk),
    .resetn     (resetn),
    .bus        (bus_if),
    .interrupt  (interrupt),
    .timer_irq  (timer_irq),
    .excp       (excp),
    .ertn       (ertn),
    .era        (era),
    .code       (code),
    .subcode    (subcode),
    .stat       (stat_if),
    .plv        (plv),
    .era_out    (era_out),
    .eentry_out (eentry_out)
  );

  csr_timer u_timer (
    .clk         (clk),
    .resetn      (resetn),
    .bus         (bus_if),
    .timer_rdata (timer_rdata),
    .timer_irq   (timer_irq),
    .tid_out     (tid_out),
    .counter_out (counter_out)
  );

  csr_read_irq u_read_irq (
    .stat        (stat_if),
    .timer_rdata (timer_rdata),
    .timer_irq   (timer_irq),
    .rdata       (rdata),
    .has_int     (has_int)
  );

endmodule

// File: design/csr_read_irq.sv
module csr_read_irq (
  exc_status_if.sink          stat,
  input  csr_pkg::csr_data_t  timer_rdata,
  input  logic                timer_irq,
  output csr_pkg::csr_data_t  rdata,
  output logic                has_int
);

  csr_pkg::int_vec_t pending;
  csr_pkg::int_vec_t enabled;

  // units return zero off their own addresses
  assign rdata = stat.rdata | timer_rdata;

  // timer bit taken straight from the timer unit
  always_comb begin
    pending = stat.is_vec;
    pending[csr_pkg::TI_BIT] = timer_irq;
  end

  assign enabled = pending & stat.lie;
  assign has_int = stat.ie && (|enabled);

endmodule

// File: design/csr_timer.sv
module csr_timer (
  input  logic                        clk,
  input  logic                        resetn,
  csr_bus_if.unit                     bus,
  output csr_pkg::csr_data_t          timer_rdata,
  output logic                        timer_irq,
  output csr_pkg::csr_data_t          tid_out,
  output logic [csr_pkg::CNT_W-1:0]   counter_out
);

  csr_pkg::csr_data_t                 tid_r;
  logic                               tcfg_en;
  logic                               tcfg_periodic;
  logic [csr_pkg::INITVAL_W-1:0]      tcfg_initval;
  csr_pkg::csr_data_t                 tval;
  csr_pkg::csr_data_t                 tcfg_word;
  logic [csr_pkg::CNT_W-1:0]          stable_cnt;
  logic                               tcfg_wen;
  logic                               ticlr_wen;
  logic                               tval_zero;

  assign tcfg_wen  = bus.wen && bus.waddr == csr_pkg::ADDR_TCFG;
  assign ticlr_wen = bus.wen && bus.waddr == csr_pkg::ADDR_TICLR;
  assign tval_zero = tcfg_en && tval == '0;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      tid_r         <= '0;
      tcfg_en       <= 1'b0;
      tcfg_periodic <= 1'b0;
    end else if (bus.wen && bus.waddr == csr_pkg::ADDR_TID) begin
      tid_r <= bus.wdata;
    end else if (tcfg_wen) begin
      tcfg_en       <= bus.wdata[csr_pkg::EN_BIT];
      tcfg_periodic <= bus.wdata[csr_pkg::PERIODIC_BIT];
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      tcfg_initval <= '0;
    end else if (tcfg_wen) begin
      tcfg_initval <= bus.wdata[csr_pkg::INITVAL_LSB +: csr_pkg::INITVAL_W];
    end
  end

  // all ones means expired and parked
  always_ff @(posedge clk) begin
    if (!resetn) begin
      tval <= '1;
    end else if (tcfg_wen && bus.wdata[csr_pkg::EN_BIT]) begin
      tval <= {bus.wdata[csr_pkg::INITVAL_LSB +: csr_pkg::INITVAL_W],
               {csr_pkg::INITVAL_LSB{1'b0}}};
    end else if (tcfg_en && tval != '1) begin
      if (tval == '0 && tcfg_periodic) begin
        tval <= {tcfg_initval, {csr_pkg::INITVAL_LSB{1'b0}}};
      end else begin
        tval <= tval - 1'b1;
      end
    end
  end

  // set beats clear in the same cycle
  always_ff @(posedge clk) begin
    if (!resetn) begin
      timer_irq <= 1'b0;
    end else if (tval_zero) begin
      timer_irq <= 1'b1;
    end else if (ticlr_wen && bus.wdata[csr_pkg::CLR_BIT]) begin
      timer_irq <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      stable_cnt <= '0;
    end else begin
      stable_cnt <= stable_cnt + 1'b1;
    end
  end

  always_comb begin
    tcfg_word = '0;
    tcfg_word[csr_pkg::EN_BIT] = tcfg_en;
    tcfg_word[csr_pkg::PERIODIC_BIT] = tcfg_periodic;
    tcfg_word[csr_pkg::INITVAL_LSB +: csr_pkg::INITVAL_W] = tcfg_initval;
  end

  // ticlr falls into default and reads as zero
  always_comb begin
    case (bus.raddr)
      csr_pkg::ADDR_TID:  timer_rdata = tid_r;
      csr_pkg::ADDR_TCFG: timer_rdata = tcfg_word;
      csr_pkg::ADDR_TVAL: timer_rdata = tval;
      default:            timer_rdata = '0;
    endcase
  end

  assign tid_out     = tid_r;
  assign counter_out = stable_cnt;

endmodule

// File: design/csr_exc_state.sv
module csr_exc_state (
  input  logic                              clk,
  input  logic                              resetn,
  csr_bus_if.unit                           bus,
  input  logic [csr_pkg::HWI_W-1:0]         interrupt,
  input  logic                              timer_irq,
  input  logic                              excp,
  input  logic                              ertn,
  input  csr_pkg::csr_data_t                era,
  input  logic [csr_pkg::ECODE_W-1:0]       code,
  input  logic [csr_pkg::ESUBCODE_W-1:0]    subcode,
  exc_status_if.src                         stat,
  output logic [csr_pkg::PLV_W-1:0]         plv,
  output csr_pkg::csr_data_t                era_out,
  output csr_pkg::csr_data_t                eentry_out
);

  logic [csr_pkg::PLV_W-1:0]                       crmd_plv;
  logic                                            crmd_ie;
  logic [csr_pkg::PLV_W-1:0]                       prmd_pplv;
  logic                                            prmd_pie;
  csr_pkg::int_vec_t                               ecfg_lie;
  logic [csr_pkg::SWI_W-1:0]                       is_sw;
  logic [csr_pkg::HWI_W-1:0]                       is_hw;
  logic [csr_pkg::ECODE_W-1:0]                     estat_ecode;
  logic [csr_pkg::ESUBCODE_W-1:0]                  estat_esubcode;
  csr_pkg::csr_data_t                              era_r;
  logic [csr_pkg::XLEN-1:csr_pkg::EENTRY_VA_LSB]   eentry_va;
  csr_pkg::csr_data_t                              save0;
  csr_pkg::csr_data_t                              save1;
  csr_pkg::csr_data_t                              save2;
  csr_pkg::csr_data_t                              save3;
  csr_pkg::int_vec_t                               is_vec;
  csr_pkg::csr_data_t                              crmd_word;
  csr_pkg::csr_data_t                              prmd_word;
  csr_pkg::csr_data_t                              ecfg_word;
  csr_pkg::csr_data_t                              estat_word;

  // control fields, excp over ertn over software writes
  always_ff @(posedge clk) begin
    if (!resetn) begin
      crmd_plv       <= '0;
      crmd_ie        <= 1'b0;
      prmd_pplv      <= '0;
      prmd_pie       <= 1'b0;
      ecfg_lie       <= '0;
      is_sw          <= '0;
      is_hw          <= '0;
      estat_ecode    <= '0;
      estat_esubcode <= '0;
    end else begin
      is_hw <= interrupt;
      if (excp) begin
        crmd_plv       <= '0;
        crmd_ie        <= 1'b0;
        prmd_pplv      <= crmd_plv;
        prmd_pie       <= crmd_ie;
        estat_ecode    <= code;
        estat_esubcode <= subcode;
      end else if (ertn) begin
        crmd_plv <= prmd_pplv;
        crmd_ie  <= prmd_pie;
      end else if (bus.wen) begin
        case (bus.waddr)
          csr_pkg::ADDR_CRMD: begin
            crmd_plv <= bus.wdata[csr_pkg::PLV_LSB +: csr_pkg::PLV_W];
            crmd_ie  <= bus.wdata[csr_pkg::IE_BIT];
          end
          csr_pkg::ADDR_PRMD: begin
            prmd_pplv <= bus.wdata[csr_pkg::PPLV_LSB +: csr_pkg::PLV_W];
            prmd_pie  <= bus.wdata[csr_pkg::PIE_BIT];
          end
          csr_pkg::ADDR_ESTAT: begin
            is_sw <= bus.wdata[csr_pkg::IS_LSB +: csr_pkg::SWI_W];
          end
          default: begin
          end
        endcase
      end
      if (bus.wen && bus.waddr == csr_pkg::ADDR_ECFG) begin
        ecfg_lie <= bus.wdata[csr_pkg::LIE_LSB +: csr_pkg::INT_W];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (excp) begin
      era_r <= era;
    end else if (!ertn && bus.wen && bus.waddr == csr_pkg::ADDR_ERA) begin
      era_r <= bus.wdata;
    end
  end

  // plain storage, no exception side effects
  always_ff @(posedge clk) begin
    if (bus.wen) begin
      case (bus.waddr)
        csr_pkg::ADDR_EENTRY: eentry_va <= bus.wdata[csr_pkg::XLEN-1:csr_pkg::EENTRY_VA_LSB];
        csr_pkg::ADDR_SAVE0:  save0 <= bus.wdata;
        csr_pkg::ADDR_SAVE1:  save1 <= bus.wdata;
        csr_pkg::ADDR_SAVE2:  save2 <= bus.wdata;
        csr_pkg::ADDR_SAVE3:  save3 <= bus.wdata;
        default: begin
        end
      endcase
    end
  end

  always_comb begin
    is_vec = '0;
    is_vec[csr_pkg::SWI_W-1:0] = is_sw;
    is_vec[csr_pkg::IS_HW_LSB +: csr_pkg::HWI_W] = is_hw;
    is_vec[csr_pkg::TI_BIT] = timer_irq;

    crmd_word = '0;
    crmd_word[csr_pkg::PLV_LSB +: csr_pkg::PLV_W] = crmd_plv;
    crmd_word[csr_pkg::IE_BIT] = crmd_ie;
    prmd_word = '0;
    prmd_word[csr_pkg::PPLV_LSB +: csr_pkg::PLV_W] = prmd_pplv;
    prmd_word[csr_pkg::PIE_BIT] = prmd_pie;
    ecfg_word = '0;
    ecfg_word[csr_pkg::LIE_LSB +: csr_pkg::INT_W] = ecfg_lie;
    estat_word = '0;
    estat_word[csr_pkg::IS_LSB +: csr_pkg::INT_W] = is_vec;
    estat_word[csr_pkg::ECODE_LSB +: csr_pkg::ECODE_W] = estat_ecode;
    estat_word[csr_pkg::ESUBCODE_LSB +: csr_pkg::ESUBCODE_W] = estat_esubcode;
  end

  // zero for addresses owned by the timer
  always_comb begin
    case (bus.raddr)
      csr_pkg::ADDR_CRMD:   stat.rdata = crmd_word;
      csr_pkg::ADDR_PRMD:   stat.rdata = prmd_word;
      csr_pkg::ADDR_ECFG:   stat.rdata = ecfg_word;
      csr_pkg::ADDR_ESTAT:  stat.rdata = estat_word;
      csr_pkg::ADDR_ERA:    stat.rdata = era_r;
      csr_pkg::ADDR_EENTRY: stat.rdata = eentry_out;
      csr_pkg::ADDR_SAVE0:  stat.rdata = save0;
      csr_pkg::ADDR_SAVE1:  stat.rdata = save1;
      csr_pkg::ADDR_SAVE2:  stat.rdata = save2;
      csr_pkg::ADDR_SAVE3:  stat.rdata = save3;
      default:              stat.rdata = '0;
    endcase
  end

  assign stat.ie     = crmd_ie;
  assign stat.lie    = ecfg_lie;
  assign stat.is_vec = is_vec;

  assign plv        = crmd_plv;
  assign era_out    = era_r;
  assign eentry_out = {eentry_va, {csr_pkg::EENTRY_VA_LSB{1'b0}}};

endmodule

// File: design/exc_status_if.sv
interface exc_status_if;

  csr_pkg::csr_data_t rdata;
  logic               ie;
  csr_pkg::int_vec_t  lie;
  csr_pkg::int_vec_t  is_vec;

  modport src (
    output rdata,
    output ie,
    output lie,
    output is_vec
  );

  modport sink (
    input rdata,
    input ie,
    input lie,
    input is_vec
  );

endinterface

// File: design/csr_bus_if.sv
interface csr_bus_if;

  logic                wen;
  csr_pkg::csr_addr_t  waddr;
  csr_pkg::csr_data_t  wdata;
  csr_pkg::csr_addr_t  raddr;

  // both register units only listen
  modport unit (
    input wen,
    input waddr,
    input wdata,
    input raddr
  );

endinterface

// File: design/csr_pkg.sv
package csr_pkg;

  localparam int XLEN   = 32;
  localparam int CSR_AW = 14;
  localparam int INT_W  = 13;
  localparam int HWI_W  = 8;
  localparam int SWI_W  = 2;
  localparam int CNT_W  = 64;

  typedef logic [CSR_AW-1:0] csr_addr_t;
  typedef logic [XLEN-1:0]   csr_data_t;
  typedef logic [INT_W-1:0]  int_vec_t;

  // csr address map
  localparam csr_addr_t ADDR_CRMD   = 14'h000;
  localparam csr_addr_t ADDR_PRMD   = 14'h001;
  localparam csr_addr_t ADDR_ECFG   = 14'h004;
  localparam csr_addr_t ADDR_ESTAT  = 14'h005;
  localparam csr_addr_t ADDR_ERA    = 14'h006;
  localparam csr_addr_t ADDR_EENTRY = 14'h00c;
  localparam csr_addr_t ADDR_SAVE0  = 14'h030;
  localparam csr_addr_t ADDR_SAVE1  = 14'h031;
  localparam csr_addr_t ADDR_SAVE2  = 14'h032;
  localparam csr_addr_t ADDR_SAVE3  = 14'h033;
  localparam csr_addr_t ADDR_TID    = 14'h040;
  localparam csr_addr_t ADDR_TCFG   = 14'h041;
  localparam csr_addr_t ADDR_TVAL   = 14'h042;
  localparam csr_addr_t ADDR_TICLR  = 14'h044;

  // crmd and prmd
  localparam int PLV_LSB  = 0;
  localparam int PLV_W    = 2;
  localparam int IE_BIT   = 2;
  localparam int PPLV_LSB = 0;
  localparam int PIE_BIT  = 2;

  // ecfg and estat
  localparam int LIE_LSB      = 0;
  localparam int IS_LSB       = 0;
  localparam int IS_HW_LSB    = 2;
  localparam int TI_BIT       = 11;
  localparam int ECODE_LSB    = 16;
  localparam int ECODE_W      = 6;
  localparam int ESUBCODE_LSB = 22;
  localparam int ESUBCODE_W   = 9;

  // entry address is 64-byte aligned
  localparam int EENTRY_VA_LSB = 6;

  // timer config
  localparam int EN_BIT       = 0;
  localparam int PERIODIC_BIT = 1;
  localparam int INITVAL_LSB  = 2;
  localparam int INITVAL_W    = XLEN - INITVAL_LSB;
  localparam int CLR_BIT      = 0;

endpackage
